//--- design/blockSettings.svh
`ifndef BLOCK_SETTINGS_SVH
`define BLOCK_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes shared by the block transfer unit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of register data and of memory addresses.
`define BLOCK_DATA_W 32

// number of registers, and so the number of bits in a register list.
`define BLOCK_REG_COUNT 16

// address step between two consecutive transfers.
`define BLOCK_WORD_BYTES 4

`endif

//--- design/blockPkg.sv
`default_nettype none

package blockPkg;

	// the addressing mode encoding equals {P, U} so the field casts straight to the mode.
	typedef enum logic [1:0] {
		modeDA = 2'b00, // decrement after.
		modeIA = 2'b01, // increment after.
		modeDB = 2'b10, // decrement before.
		modeIB = 2'b11  // increment before.
	} blockMode;

	// phases of one LDM or STM.
	typedef enum logic [1:0] {
		seqIdle     = 2'b00, // waiting for a decoded instruction.
		seqTransfer = 2'b01, // one memory strobe per cycle.
		seqDrain    = 2'b10, // last load data returns.
		seqBase     = 2'b11  // base write and done.
	} seqState;

endpackage

`default_nettype wire

//--- design/regListSelector.sv
`include "blockSettings.svh"
`timescale 1ns/1ps
`default_nettype none

module regListSelector (
	input  wire logic                           first,
	input  wire logic [`BLOCK_REG_COUNT-1:0]    instrList,
	input  wire logic [`BLOCK_REG_COUNT-1:0]    listNow,
	output logic [`BLOCK_REG_COUNT-1:0]         listNext,
	output logic [$clog2(`BLOCK_REG_COUNT)-1:0] selIdx
);

	localparam int idxW = $clog2(`BLOCK_REG_COUNT);

	logic [`BLOCK_REG_COUNT-1:0] scanList;

	// the first step sees the list straight from the instruction.
	assign scanList = first ? instrList : listNow;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lowest set register wins.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		selIdx = '0;
		// scanning downwards leaves the lowest hit in selIdx.
		for (int i = `BLOCK_REG_COUNT - 1; i >= 0; i--) begin
			if (scanList[i]) begin
				selIdx = idxW'(i);
			end
		end
	end

	always_comb begin
		listNext = scanList;
		listNext[selIdx] = 1'b0; // an empty list stays empty.
	end

endmodule

`default_nettype wire

//--- design/blockDecoder.sv
`include "blockSettings.svh"
`timescale 1ns/1ps
`default_nettype none

module blockDecoder import blockPkg::*; (
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic                          start,
	input  wire logic [31:0]                   instr,
	input  wire logic                          busy,
	output logic                               decoded,
	output logic                               illegal,
	output blockMode                           mode,
	output logic                               isLoad,
	output logic                               writeBack,
	output logic [$clog2(`BLOCK_REG_COUNT)-1:0] baseIdx,
	output logic [`BLOCK_REG_COUNT-1:0]        regList,
	output logic [$clog2(`BLOCK_REG_COUNT):0]  listCount
);

	localparam int countW = $clog2(`BLOCK_REG_COUNT) + 1;

	logic accept;
	logic classOk;
	logic [countW-1:0] bitCount;

	assign accept = start && !busy; // a start during an instruction is dropped.
	assign classOk = instr[27:25] == 3'b100;

	// population count of the register list.
	always_comb begin
		bitCount = '0;
		for (int i = 0; i < `BLOCK_REG_COUNT; i++) begin
			bitCount = bitCount + countW'(instr[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decoded <= 1'b0;
			illegal <= 1'b0;
		end else begin
			decoded <= accept && classOk;
			illegal <= accept && !classOk;
		end
	end

	// fields stay put until the next legal instruction so the sequencer can read them throughout.
	always_ff @(posedge clk) begin
		if (accept && classOk) begin
			mode      <= blockMode'(instr[24:23]); // {P, U}.
			writeBack <= instr[21];
			isLoad    <= instr[20];
			baseIdx   <= instr[19:16];
			regList   <= instr[`BLOCK_REG_COUNT-1:0];
			listCount <= bitCount;
		end
	end

endmodule

`default_nettype wire

//--- design/blockSequencer.sv
`include "blockSettings.svh"
`timescale 1ns/1ps
`default_nettype none

module blockSequencer import blockPkg::*; (
	input  wire logic                                clk,
	input  wire logic                                rstN,
	input  wire logic                                decoded,
	input  wire blockMode                            mode,
	input  wire logic                                isLoad,
	input  wire logic                                writeBack,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] baseIdx,
	input  wire logic [`BLOCK_REG_COUNT-1:0]         regList,
	input  wire logic [$clog2(`BLOCK_REG_COUNT):0]   listCount,
	input  wire logic [`BLOCK_DATA_W-1:0]            baseValue,
	input  wire logic [`BLOCK_DATA_W-1:0]            storeData,
	input  wire logic [`BLOCK_DATA_W-1:0]            memReadData,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] selIdx,
	input  wire logic [`BLOCK_REG_COUNT-1:0]         listNext,
	output logic                                     first,
	output logic [`BLOCK_REG_COUNT-1:0]              listNow,
	output logic                                     busy,
	output logic                                     done,
	output logic                                     memRead,
	output logic                                     memWrite,
	output logic [`BLOCK_DATA_W-1:0]                 memAddr,
	output logic [`BLOCK_DATA_W-1:0]                 memWriteData,
	output logic                                     ldValid,
	output logic [$clog2(`BLOCK_REG_COUNT)-1:0]      ldIdx,
	output logic [`BLOCK_DATA_W-1:0]                 ldData,
	output logic                                     baseWe,
	output logic [`BLOCK_DATA_W-1:0]                 baseData,
	output logic [$clog2(`BLOCK_REG_COUNT)-1:0]      readIdx
);

	localparam int dataW = `BLOCK_DATA_W;
	localparam logic [dataW-1:0] step = `BLOCK_WORD_BYTES;

	seqState state;
	logic transfer;
	logic baseLoaded;
	logic [$clog2(`BLOCK_REG_COUNT):0] remaining;
	logic [dataW-1:0] span;
	logic [dataW-1:0] startAddr;
	logic [dataW-1:0] endBase;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Start address and new base.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign span = dataW'(listCount) * step;

	always_comb begin
		case (mode)
			modeIA: startAddr = baseValue;
			modeIB: startAddr = baseValue + step;
			modeDA: startAddr = baseValue - span + step;
			default: startAddr = baseValue - span;
		endcase
		endBase = (mode == modeIA || mode == modeIB) ? baseValue + span : baseValue - span;
	end

	assign transfer = state == seqTransfer;
	assign busy = decoded || state != seqIdle;
	assign memRead = transfer && isLoad;
	assign memWrite = transfer && !isLoad;
	assign readIdx = selIdx; // store data comes from the selected register.
	assign memWriteData = storeData;
	assign ldData = memReadData;
	assign baseWe = state == seqBase && writeBack && !baseLoaded && listCount != '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state      <= seqIdle;
			done       <= 1'b0;
			ldValid    <= 1'b0;
			first      <= 1'b0;
			baseLoaded <= 1'b0;
			remaining  <= '0;
		end else begin
			done    <= 1'b0;
			ldValid <= memRead; // data lands one cycle after its strobe.
			case (state)
				seqIdle: begin
					if (decoded) begin
						state      <= (regList == '0) ? seqBase : seqTransfer;
						first      <= 1'b1;
						baseLoaded <= 1'b0;
						remaining  <= listCount;
					end
				end
				seqTransfer: begin
					first     <= 1'b0;
					remaining <= remaining - 1'b1;
					if (isLoad && selIdx == baseIdx) begin
						baseLoaded <= 1'b1; // the loaded value beats the written-back base.
					end
					if (remaining == 1) begin
						state <= isLoad ? seqDrain : seqBase;
					end
				end
				seqDrain: state <= seqBase;
				default: begin
					done  <= 1'b1;
					state <= seqIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == seqIdle && decoded) begin
			memAddr  <= startAddr;
			baseData <= endBase;
		end else if (transfer) begin
			memAddr <= memAddr + step;
		end
		if (transfer) begin
			listNow <= listNext;
		end
		ldIdx <= selIdx;
	end

endmodule

`default_nettype wire

//--- design/registerWriteback.sv
`include "blockSettings.svh"
`timescale 1ns/1ps
`default_nettype none

module registerWriteback (
	input  wire logic                                clk,
	input  wire logic                                rstN,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] readIdx,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] baseIdx,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] dbgIdx,
	input  wire logic                                ldValid,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] ldIdx,
	input  wire logic [`BLOCK_DATA_W-1:0]            ldData,
	input  wire logic                                baseWe,
	input  wire logic [`BLOCK_DATA_W-1:0]            baseData,
	output logic [`BLOCK_DATA_W-1:0]                 storeData,
	output logic [`BLOCK_DATA_W-1:0]                 baseValue,
	output logic [`BLOCK_DATA_W-1:0]                 dbgData
);

	logic [`BLOCK_DATA_W-1:0] regs [`BLOCK_REG_COUNT];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write ports.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `BLOCK_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (ldValid) begin
				regs[ldIdx] <= ldData;
			end
			// the sequencer never asserts both ports in one cycle.
			if (baseWe) begin
				regs[baseIdx] <= baseData;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read ports.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign storeData = regs[readIdx]; // data for the current store strobe.
	assign baseValue = regs[baseIdx]; // sampled by the sequencer as R.
	assign dbgData = regs[dbgIdx];

endmodule

`default_nettype wire

//--- design/blockTransferTop.sv
`include "blockSettings.svh"
`timescale 1ns/1ps
`default_nettype none

module blockTransferTop import blockPkg::*; (
	input  wire logic                                clk,
	input  wire logic                                rstN,
	input  wire logic                                start,
	input  wire logic [31:0]                         instr,
	output logic                                     busy,
	output logic                                     done,
	output logic                                     illegal,
	output logic                                     memRead,
	output logic                                     memWrite,
	output logic [`BLOCK_DATA_W-1:0]                 memAddr,
	output logic [`BLOCK_DATA_W-1:0]                 memWriteData,
	input  wire logic [`BLOCK_DATA_W-1:0]            memReadData,
	input  wire logic [$clog2(`BLOCK_REG_COUNT)-1:0] dbgIdx,
	output logic [`BLOCK_DATA_W-1:0]                 dbgData
);

	localparam int idxW = $clog2(`BLOCK_REG_COUNT);

	logic decoded;
	blockMode mode;
	logic isLoad;
	logic writeBack;
	logic [idxW-1:0] baseIdx;
	logic [`BLOCK_REG_COUNT-1:0] regList;
	logic [idxW:0] listCount;
	logic first;
	logic [`BLOCK_REG_COUNT-1:0] listNow;
	logic [`BLOCK_REG_COUNT-1:0] listNext;
	logic [idxW-1:0] selIdx;
	logic [idxW-1:0] readIdx;
	logic ldValid;
	logic [idxW-1:0] ldIdx;
	logic [`BLOCK_DATA_W-1:0] ldData;
	logic baseWe;
	logic [`BLOCK_DATA_W-1:0] baseData;
	logic [`BLOCK_DATA_W-1:0] baseValue;
	logic [`BLOCK_DATA_W-1:0] storeData;

	blockDecoder blockDecoder_inst (
		.clk(clk), .rstN(rstN), .start(start), .instr(instr), .busy(busy),
		.decoded(decoded), .illegal(illegal), .mode(mode), .isLoad(isLoad),
		.writeBack(writeBack), .baseIdx(baseIdx), .regList(regList), .listCount(listCount)
	);

	regListSelector regListSelector_inst (
		.first(first), .instrList(regList), .listNow(listNow),
		.listNext(listNext), .selIdx(selIdx)
	);

	blockSequencer blockSequencer_inst (
		.clk(clk), .rstN(rstN), .decoded(decoded), .mode(mode), .isLoad(isLoad),
		.writeBack(writeBack), .baseIdx(baseIdx), .regList(regList),
		.listCount(listCount), .baseValue(baseValue), .storeData(storeData),
		.memReadData(memReadData), .selIdx(selIdx), .listNext(listNext),
		.first(first), .listNow(listNow), .busy(busy), .done(done),
		.memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
		.memWriteData(memWriteData), .ldValid(ldValid), .ldIdx(ldIdx),
		.ldData(ldData), .baseWe(baseWe), .baseData(baseData), .readIdx(readIdx)
	);

	registerWriteback registerWriteback_inst (
		.clk(clk), .rstN(rstN), .readIdx(readIdx), .baseIdx(baseIdx), .dbgIdx(dbgIdx),
		.ldValid(ldValid), .ldIdx(ldIdx), .ldData(ldData), .baseWe(baseWe),
		.baseData(baseData), .storeData(storeData), .baseValue(baseValue),
		.dbgData(dbgData)
	);

endmodule

`default_nettype wire

//--- tests/blockTransferTb.sv
`timescale 1ns/1ps
`default_nettype none

module blockTransferTb;

	localparam int timeoutCycles = 60 * 20; // instructions times cycles per instruction.

	logic clk = 1'b0;
	logic rstN;
	logic start;
	logic [31:0] instr;
	logic busy;
	logic done;
	logic illegal;
	logic memRead;
	logic memWrite;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic [31:0] memReadData = '0;
	logic [3:0] dbgIdx;
	logic [31:0] dbgData;

	logic [31:0] mem [64];
	logic [31:0] modelRegs [16];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic expWrite [$];
	int unsigned seed = 27;
	int errors = 0;
	int cycles = 0;
	int doneCount = 0;
	int illegalCount = 0;
	int opsIssued = 0;

	blockTransferTop blockTransferTop_inst (
		.clk(clk), .rstN(rstN), .start(start), .instr(instr), .busy(busy), .done(done),
		.illegal(illegal), .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
		.memWriteData(memWriteData), .memReadData(memReadData), .dbgIdx(dbgIdx),
		.dbgData(dbgData)
	);

	always #50 clk = ~clk;

	function automatic logic [15:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[30:15]; // the low bits of an LCG repeat too quickly.
	endfunction

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data memory with one cycle read latency, and the strobe monitor.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		cycles++;
		if (done) doneCount++;
		if (illegal) illegalCount++;
		if (memRead || memWrite) begin
			if (expAddr.size() == 0) begin
				$display("memory strobe at address %h while no transfer was due", memAddr);
				errors++;
			end else begin
				check("strobe kind", 32'(expWrite.pop_front()), 32'(memWrite));
				check("address", expAddr.pop_front(), memAddr);
				if (memWrite && expData.size() != 0) begin
					check("store data", expData.pop_front(), memWriteData);
				end
			end
		end
		if (memRead) memReadData <= mem[memAddr[7:2]];
		if (memWrite) mem[memAddr[7:2]] = memWriteData;
		if (cycles >= timeoutCycles) begin
			$display("timeout, the run did not end within %0d cycles", timeoutCycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic applyReset();
		rstN <= 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < 16; i++) modelRegs[i] = '0;
	endtask

	// waits counts edges from the start pulse to the done or illegal pulse.
	task automatic issue(input logic [31:0] word, input logic interfere, output int waits);
		@(posedge clk);
		start <= 1'b1;
		instr <= word;
		@(posedge clk);
		check("busy before start", 32'd0, 32'(busy));
		start <= interfere; // lands while busy, so it must be dropped.
		instr <= {word[31:16], ~word[15:0]};
		waits = 1;
		do begin
			@(posedge clk);
			start <= 1'b0;
			waits++;
			check("busy", 32'(!done && !illegal), 32'(busy)); // high until the closing pulse.
		end while (!done && !illegal);
	endtask

	task automatic runOp(input logic [1:0] pu, input logic w, input logic l, input logic [3:0] rn,
			input logic [15:0] list, input logic interfere);
		logic [31:0] base;
		logic [31:0] addr;
		logic [31:0] newRegs [16];
		int n;
		int waits;
		n = $countones(list);
		base = modelRegs[rn];
		case (pu) // {P, U}.
			2'b01: addr = base;
			2'b11: addr = base + 32'd4;
			2'b00: addr = base - 32'(4 * n) + 32'd4;
			default: addr = base - 32'(4 * n);
		endcase
		newRegs = modelRegs;
		for (int i = 0; i < 16; i++) begin
			if (list[i]) begin
				expAddr.push_back(addr);
				expWrite.push_back(!l);
				if (!l) expData.push_back(modelRegs[i]); // a stored base register gives R.
				if (l) newRegs[i] = mem[addr[7:2]];
				addr = addr + 32'd4;
			end
		end
		if (w && n > 0 && !(l && list[rn])) begin
			newRegs[rn] = pu[0] ? base + 32'(4 * n) : base - 32'(4 * n);
		end
		issue({4'hE, 3'b100, pu, 1'b0, w, l, rn, list}, interfere, waits);
		check("latency", 32'(4 + n + ((l && n > 0) ? 1 : 0)), 32'(waits));
		check("illegal on legal instruction", 32'd0, 32'(illegal));
		if (expAddr.size() != 0) begin
			$display("%0d memory transfers never happened", expAddr.size());
			errors++;
		end
		expAddr.delete();
		expData.delete();
		expWrite.delete();
		modelRegs = newRegs;
		opsIssued++;
	endtask

	task automatic readReg(input logic [3:0] idx, output logic [31:0] value);
		@(posedge clk);
		dbgIdx <= idx;
		@(posedge clk);
		value = dbgData;
	endtask

	task automatic checkRegs();
		logic [31:0] value;
		for (int i = 0; i < 16; i++) begin
			readReg(4'(i), value);
			check($sformatf("r%0d", i), modelRegs[i], value);
		end
	endtask

	// loads the wanted base through a register that already points into memory.
	task automatic setBase(input logic [3:0] rn, input logic [31:0] value);
		int ptr;
		ptr = -1;
		for (int i = 15; i >= 0; i--) begin
			if (modelRegs[i] < 32'd256 && modelRegs[i][1:0] == 2'b00) ptr = i;
		end
		if (ptr < 0) begin
			applyReset();
			ptr = 0;
		end
		mem[modelRegs[ptr][7:2]] = value;
		runOp(2'b01, 1'b0, 1'b1, 4'(ptr), 16'(1) << rn, 1'b0);
	endtask

	initial begin
		int waits;
		logic [1:0] pu;
		logic w;
		logic l;
		logic [3:0] rn;
		logic [15:0] list;
		logic [31:0] value;
		start <= 1'b0;
		instr <= '0;
		dbgIdx <= '0;
		for (int i = 0; i < 64; i++) mem[i] = {nextRand(), nextRand()};
		applyReset();
		for (int iter = 0; iter < 20; iter++) begin
			pu = 2'(nextRand());
			w = 1'(nextRand());
			l = iter < 4 || 1'(nextRand()); // the first few fill the register file.
			rn = 4'(nextRand());
			list = nextRand();
			value = 32'd64 + 32'(nextRand() % 16'd32) * 32'd4;
			setBase(rn, value);
			runOp(pu, w, l, rn, list, iter % 6 == 2);
			readReg(rn, value);
			check("base", modelRegs[rn], value);
			if (iter % 5 == 4) checkRegs();
		end
		setBase(4'd5, 32'd128);
		runOp(2'b00, 1'b1, 1'b1, 4'd5, 16'h0000, 1'b0);
		runOp(2'b11, 1'b1, 1'b0, 4'd5, 16'h0000, 1'b0);
		setBase(4'd3, 32'd100);
		runOp(2'b10, 1'b1, 1'b1, 4'd3, 16'h00F8, 1'b0);
		setBase(4'd7, 32'd160);
		runOp(2'b00, 1'b1, 1'b0, 4'd7, 16'h81C0, 1'b1);
		issue({4'hE, 3'b011, 25'h0A5F0F}, 1'b0, waits);
		check("illegal latency", 32'd2, 32'(waits));
		check("done on illegal instruction", 32'd0, 32'(done));
		repeat (4) @(posedge clk);
		checkRegs();
		check("done count", 32'(opsIssued), 32'(doneCount));
		check("illegal count", 32'd1, 32'(illegalCount));
		$display("%0d errors over %0d instructions", errors, opsIssued);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/blockPkg.sv
design/regListSelector.sv
design/blockDecoder.sv
design/blockSequencer.sv
design/registerWriteback.sv
design/blockTransferTop.sv
tests/blockTransferTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f sources.f --top-module blockTransferTb -o blockTransferSim
./obj_dir/blockTransferSim > sim.log
cat sim.log

if grep -q "^Everything OK$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
